// File: include/sdSpi_config.svh
// SD SPI front end configuration

`ifndef SD_SPI_CONFIG_SVH
`define SD_SPI_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// SPI clock divisors
//////////////////////////////////////////////////////////////////////

// Half-period count for the slow clock, about 400 kHz class
`define SD_SLOW_DIV 6'd63

// Half-period count for the fast clock
`define SD_FAST_DIV 6'd1

//////////////////////////////////////////////////////////////////////
// Protocol counts
//////////////////////////////////////////////////////////////////////

// Filler bytes at power-up, 8 clocks each
`define SD_INIT_BYTES 10

// Response bytes polled before a timeout
`define SD_POLL_MAX 8

`endif

// File: design/sdSpiPkg.sv
// SD SPI shared types and constants

package sdSpiPkg;

   //////////////////////////////////////////////////////////////////////
   // Physical layer operations
   //////////////////////////////////////////////////////////////////////

   // Operation selector, sampled by the physical layer while idle
   typedef enum logic [2:0]
   {
      SPI_NOP  = 3'd0,
      SPI_CSL  = 3'd1,
      SPI_CSH  = 3'd2,
      SPI_FAST = 3'd3,
      SPI_SLOW = 3'd4,
      SPI_TR   = 3'd5
   } spiOp_t;

   //////////////////////////////////////////////////////////////////////
   // SD protocol bytes
   //////////////////////////////////////////////////////////////////////

   // Filler sent while clocking and polling
   localparam logic [7:0] SD_IDLE_BYTE = 8'hff;

   // Leading bits of every command byte
   localparam logic [1:0] SD_START_BITS = 2'b01;

endpackage

// File: design/sdSpiPhy.sv
// SD SPI physical layer

`timescale 1ns/10ps

`include "sdSpi_config.svh"

module sdSpiPhy
(
   input  logic              clk,
   input  logic              rst,
   input  sdSpiPkg::spiOp_t  spiOp,
   input  logic [7:0]        spiTxd,
   output logic [7:0]        spiRxd,
   input  logic              spiMiso,
   output logic              spiMosi,
   output logic              spiSclk,
   output logic              spiCs,
   output logic              spiDone
);

   import sdSpiPkg::*;

   // Byte engine states
   typedef enum logic [2:0]
   {
      stReset    = 3'd0,
      stIdle     = 3'd1,
      stClkLow   = 3'd2,
      stClkHigh  = 3'd3,
      stLastHigh = 3'd4,
      stLastLow  = 3'd5
   } phyState_t;

   phyState_t   state;
   logic [2:0]  bitCnt;
   logic [5:0]  halfCnt;
   logic [5:0]  clkDiv;
   logic [7:0]  txd;
   logic [7:0]  rxd;

   //////////////////////////////////////////////////////////////////////
   // Control FSM and shift engine
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state   <= stReset;
         spiDone <= 1'b0;
         spiCs   <= 1'b1;
         bitCnt  <= 3'd0;
         halfCnt <= 6'd0;
         clkDiv  <= `SD_SLOW_DIV;
         txd     <= SD_IDLE_BYTE;
         rxd     <= SD_IDLE_BYTE;
      end
      else
      begin
         // Done is a single cycle strobe
         spiDone <= 1'b0;
         case (state)
            // Come up at slow speed
            stReset:
            begin
               clkDiv <= `SD_SLOW_DIV;
               state  <= stIdle;
            end
            // Decode one operation per cycle
            stIdle:
            begin
               case (spiOp)
                  SPI_NOP:
                  begin
                     state <= stIdle;
                  end
                  SPI_CSL:
                     spiCs <= 1'b0;
                  SPI_CSH:
                     spiCs <= 1'b1;
                  SPI_FAST:
                     clkDiv <= `SD_FAST_DIV;
                  SPI_SLOW:
                     clkDiv <= `SD_SLOW_DIV;
                  SPI_TR:
                  begin
                     // Load byte, first bit already on MOSI
                     halfCnt <= clkDiv;
                     bitCnt  <= 3'd7;
                     txd     <= spiTxd;
                     state   <= stClkLow;
                  end
                  default:
                     state <= stIdle;
               endcase
            end
            // SCLK low, card drives MISO
            stClkLow:
            begin
               if (halfCnt == 6'd0)
               begin
                  // Sample at the end of the low phase
                  halfCnt <= clkDiv;
                  rxd     <= {rxd[6:0], spiMiso};
                  state   <= stClkHigh;
               end
               else
                  halfCnt <= halfCnt - 6'd1;
            end
            // SCLK high, card has latched MOSI
            stClkHigh:
            begin
               if (halfCnt == 6'd0)
               begin
                  halfCnt <= clkDiv;
                  if (bitCnt == 3'd0)
                     state <= stLastHigh;
                  else
                  begin
                     // Next bit out, refill with ones
                     txd    <= {txd[6:0], 1'b1};
                     bitCnt <= bitCnt - 3'd1;
                     state  <= stClkLow;
                  end
               end
               else
                  halfCnt <= halfCnt - 6'd1;
            end
            // Hold time after the last rising edge
            stLastHigh:
            begin
               if (halfCnt == 6'd0)
               begin
                  halfCnt <= clkDiv;
                  state   <= stLastLow;
               end
               else
                  halfCnt <= halfCnt - 6'd1;
            end
            // Guard phase, SCLK still parked high so no extra edge
            stLastLow:
            begin
               if (halfCnt == 6'd0)
               begin
                  halfCnt <= clkDiv;
                  spiDone <= 1'b1;
                  state   <= stIdle;
               end
               else
                  halfCnt <= halfCnt - 6'd1;
            end
            default:
               state <= stIdle;
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Pin outputs
   //////////////////////////////////////////////////////////////////////

   // Clock idles high, low only during data low phases
   assign spiSclk = (state != stClkLow);
   // MSB first
   assign spiMosi = txd[7];
   assign spiRxd  = rxd;

endmodule

// File: design/sdCmdSequencer.sv
// SD command sequencer

`timescale 1ns/10ps

`include "sdSpi_config.svh"

module sdCmdSequencer
(
   input  logic              clk,
   input  logic              rst,
   input  logic              initStart,
   input  logic              cmdStart,
   input  logic [5:0]        cmdIndex,
   input  logic [31:0]       cmdArg,
   input  logic              setFast,
   input  logic              setSlow,
   output sdSpiPkg::spiOp_t  spiOp,
   output logic [7:0]        spiTxd,
   input  logic [7:0]        spiRxd,
   input  logic              spiDone,
   output logic              busy,
   output logic              cmdDone,
   output logic [7:0]        resp,
   output logic              respTimeout
);

   import sdSpiPkg::*;

   // Sequencer states
   typedef enum logic [3:0]
   {
      stIdle    = 4'd0,
      stInitCs  = 4'd1,
      stInit    = 4'd2,
      stCmdCs   = 4'd3,
      stPre     = 4'd4,
      stFrame   = 4'd5,
      stPoll    = 4'd6,
      stEndCs   = 4'd7,
      stTrail   = 4'd8
   } seqState_t;

   // Last value of the shared byte counter per phase
   localparam logic [3:0] InitLast  = 4'(`SD_INIT_BYTES - 1);
   localparam logic [3:0] FrameLast = 4'd5;
   localparam logic [3:0] PollLast  = 4'(`SD_POLL_MAX - 1);

   seqState_t    state;
   logic         pending;
   logic [3:0]   byteCnt;
   logic [39:0]  frameSr;
   logic [6:0]   crc;
   logic [7:0]   nextByte;

   //////////////////////////////////////////////////////////////////////
   // CRC7, polynomial x^7 + x^3 + 1
   //////////////////////////////////////////////////////////////////////

   function automatic logic [6:0] crc7Byte(input logic [6:0] crcIn, input logic [7:0] data);
      logic [6:0] c;
      logic       fb;
      c = crcIn;
      // MSB first, one bit per step
      for (int i = 7; i >= 0; i--)
      begin
         fb = c[6] ^ data[i];
         c  = {c[5:3], c[2] ^ fb, c[1:0], fb};
      end
      return c;
   endfunction

   // Frame bytes come from the shifter, the last one is CRC plus stop bit
   always_comb
   begin
      if (state == stFrame)
         nextByte = (byteCnt == FrameLast) ? {crc, 1'b1} : frameSr[39:32];
      else
         nextByte = SD_IDLE_BYTE;
   end

   //////////////////////////////////////////////////////////////////////
   // Sequencer FSM
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state       <= stIdle;
         spiOp       <= SPI_NOP;
         pending     <= 1'b0;
         byteCnt     <= 4'd0;
         cmdDone     <= 1'b0;
         resp        <= SD_IDLE_BYTE;
         respTimeout <= 1'b0;
      end
      else
      begin
         // Operations and done are one cycle wide
         spiOp   <= SPI_NOP;
         cmdDone <= 1'b0;
         case (state)
            // Accept one request, init has priority
            stIdle:
            begin
               if (initStart)
               begin
                  resp        <= SD_IDLE_BYTE;
                  respTimeout <= 1'b0;
                  state       <= stInitCs;
               end
               else if (cmdStart)
               begin
                  resp        <= SD_IDLE_BYTE;
                  respTimeout <= 1'b0;
                  frameSr     <= {SD_START_BITS, cmdIndex, cmdArg};
                  crc         <= 7'd0;
                  state       <= stCmdCs;
               end
               else if (setFast)
                  spiOp <= SPI_FAST;
               else if (setSlow)
                  spiOp <= SPI_SLOW;
            end
            // Card wants CS high during power-up clocks
            stInitCs:
            begin
               spiOp   <= SPI_CSH;
               byteCnt <= 4'd0;
               state   <= stInit;
            end
            stCmdCs:
            begin
               spiOp <= SPI_CSL;
               state <= stPre;
            end
            stEndCs:
            begin
               spiOp <= SPI_CSH;
               state <= stTrail;
            end
            // Byte transfer states
            default:
            begin
               if (!pending)
               begin
                  // Issue the byte, physical layer is idle here
                  spiOp   <= SPI_TR;
                  spiTxd  <= nextByte;
                  pending <= 1'b1;
                  if (state == stFrame && byteCnt != FrameLast)
                  begin
                     frameSr <= {frameSr[31:0], 8'h00};
                     crc     <= crc7Byte(crc, frameSr[39:32]);
                  end
               end
               else if (spiDone)
               begin
                  pending <= 1'b0;
                  case (state)
                     stInit:
                     begin
                        if (byteCnt == InitLast)
                        begin
                           cmdDone <= 1'b1;
                           state   <= stIdle;
                        end
                        else
                           byteCnt <= byteCnt + 4'd1;
                     end
                     stPre:
                     begin
                        byteCnt <= 4'd0;
                        state   <= stFrame;
                     end
                     stFrame:
                     begin
                        if (byteCnt == FrameLast)
                        begin
                           byteCnt <= 4'd0;
                           state   <= stPoll;
                        end
                        else
                           byteCnt <= byteCnt + 4'd1;
                     end
                     stPoll:
                     begin
                        // R1 has a zero MSB
                        if (!spiRxd[7])
                        begin
                           resp  <= spiRxd;
                           state <= stEndCs;
                        end
                        else if (byteCnt == PollLast)
                        begin
                           resp        <= SD_IDLE_BYTE;
                           respTimeout <= 1'b1;
                           state       <= stEndCs;
                        end
                        else
                           byteCnt <= byteCnt + 4'd1;
                     end
                     // Trailing byte lets the card release MISO
                     default:
                     begin
                        cmdDone <= 1'b1;
                        state   <= stIdle;
                     end
                  endcase
               end
            end
         endcase
      end
   end

   // Busy drops together with the done strobe
   assign busy = (state != stIdle);

endmodule

// File: design/sdSpiTop.sv
// SD SPI front end top level

`timescale 1ns/10ps

module sdSpiTop
(
   input  logic         clk,
   input  logic         rst,
   input  logic         initStart,
   input  logic         cmdStart,
   input  logic [5:0]   cmdIndex,
   input  logic [31:0]  cmdArg,
   input  logic         setFast,
   input  logic         setSlow,
   output logic         busy,
   output logic         cmdDone,
   output logic [7:0]   resp,
   output logic         respTimeout,
   input  logic         sdMiso,
   output logic         sdMosi,
   output logic         sdSclk,
   output logic         sdCs
);

   import sdSpiPkg::*;

   // Sequencer to physical layer
   spiOp_t       spiOp;
   logic [7:0]   spiTxd;
   logic [7:0]   spiRxd;
   logic         spiDone;

   // Command level control
   sdCmdSequencer sdCmdSequencer_inst
   (
      .clk         (clk),
      .rst         (rst),
      .initStart   (initStart),
      .cmdStart    (cmdStart),
      .cmdIndex    (cmdIndex),
      .cmdArg      (cmdArg),
      .setFast     (setFast),
      .setSlow     (setSlow),
      .spiOp       (spiOp),
      .spiTxd      (spiTxd),
      .spiRxd      (spiRxd),
      .spiDone     (spiDone),
      .busy        (busy),
      .cmdDone     (cmdDone),
      .resp        (resp),
      .respTimeout (respTimeout)
   );

   // Card pins
   sdSpiPhy sdSpiPhy_inst
   (
      .clk     (clk),
      .rst     (rst),
      .spiOp   (spiOp),
      .spiTxd  (spiTxd),
      .spiRxd  (spiRxd),
      .spiMiso (sdMiso),
      .spiMosi (sdMosi),
      .spiSclk (sdSclk),
      .spiCs   (sdCs),
      .spiDone (spiDone)
   );

endmodule

// File: tests/sdCardModel.sv
// Behavioral SD card in SPI mode

`timescale 1ns/10ps

module sdCardModel
(
   input  logic         rst,
   input  logic         sclk,
   input  logic         cs,
   input  logic         mosi,
   output logic         miso,
   input  logic [7:0]   respDelay,
   input  logic [7:0]   r1Value,
   input  logic         injectCrcError,
   output logic [5:0]   capIndex,
   output logic [31:0]  capArg,
   output logic [7:0]   capCrcByte,
   output logic         crcOk,
   output logic [15:0]  initClocks,
   output logic [15:0]  frameCount
);

   logic [2:0]  bitCnt = 3'd0;
   logic [7:0]  rxSr = 8'hff;
   logic [7:0]  txByte = 8'hff;
   logic        misoReg = 1'b1;
   logic [7:0]  answer = 8'hff;
   logic [6:0]  expCrc;
   logic [7:0]  frame [6];
   int          nCap = 0;
   int          respIdx = 0;

   initial
   begin
      capIndex   = 6'd0;
      capArg     = 32'd0;
      capCrcByte = 8'd0;
      crcOk      = 1'b0;
      initClocks = 16'd0;
      frameCount = 16'd0;
   end

   // Long division of the 40 frame bits by x^7 + x^3 + 1
   function automatic logic [6:0] crc7Remainder(input logic [39:0] msg);
      logic [46:0] work;
      work = {msg, 7'd0};
      for (int i = 46; i >= 7; i--)
      begin
         if (work[i])
            work[i -: 8] = work[i -: 8] ^ 8'h89;
      end
      return work[6:0];
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Receive side, MOSI taken on rising SCLK
   //////////////////////////////////////////////////////////////////////

   always @(posedge sclk)
   begin
      if (rst)
      begin
         bitCnt     = 3'd0;
         nCap       = 0;
         respIdx    = 0;
         txByte     = 8'hff;
         initClocks = 16'd0;
         frameCount = 16'd0;
      end
      else if (cs === 1'b1)
      begin
         // Deselected, count clocks and drop any partial frame
         initClocks = initClocks + 16'd1;
         bitCnt     = 3'd0;
         nCap       = 0;
         respIdx    = 0;
         txByte     = 8'hff;
      end
      else if (cs === 1'b0)
      begin
         rxSr = {rxSr[6:0], mosi};
         if (bitCnt != 3'd7)
            bitCnt = bitCnt + 3'd1;
         else
         begin
            bitCnt = 3'd0;
            if (nCap == 6)
               respIdx = respIdx + 1;
            // Frame starts with a 01 byte
            else if (nCap > 0 || rxSr[7:6] == 2'b01)
            begin
               frame[nCap] = rxSr;
               nCap = nCap + 1;
               if (nCap == 6)
               begin
                  capIndex   = frame[0][5:0];
                  capArg     = {frame[1], frame[2], frame[3], frame[4]};
                  capCrcByte = frame[5];
                  expCrc     = crc7Remainder({frame[0], capArg}) ^ {6'd0, injectCrcError};
                  crcOk      = (frame[5] == {expCrc, 1'b1});
                  // CRC error plus idle bit
                  answer     = crcOk ? r1Value : 8'h09;
                  frameCount = frameCount + 16'd1;
               end
            end
            // Byte for the next slot, R1 after respDelay filler bytes
            txByte = (nCap == 6 && respIdx == respDelay) ? answer : 8'hff;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Transmit side, MISO changed on falling SCLK
   //////////////////////////////////////////////////////////////////////

   always @(negedge sclk)
   begin
      if (cs === 1'b0)
         misoReg <= txByte[3'd7 - bitCnt];
   end

   // Released line reads as ones
   assign miso = (cs === 1'b0) ? misoReg : 1'b1;

endmodule

// File: tests/sdSpiTb.sv
// SD SPI front end testbench

`timescale 1ns/10ps

`include "sdSpi_config.svh"

module sdSpiTb;

   // Speed 0 keeps, 1 selects fast, 2 selects slow
   // Expected CRC byte of zero means unchecked
   typedef struct packed
   {
      logic [1:0]   speed;
      logic         randArg;
      logic [5:0]   index;
      logic [31:0]  arg;
      logic         badCrc;
      logic [7:0]   delay;
      logic [7:0]   r1;
      logic [7:0]   expResp;
      logic         expTimeout;
      logic [7:0]   expCrcByte;
   } cmdRow_t;

   localparam int DoneLimit = 40000;
   localparam int BusyLimit = 20;

   logic         clk = 1'b0;
   logic         rst;
   logic         initStart;
   logic         cmdStart;
   logic [5:0]   cmdIndex;
   logic [31:0]  cmdArg;
   logic         setFast;
   logic         setSlow;
   logic         busy;
   logic         cmdDone;
   logic [7:0]   resp;
   logic         respTimeout;
   logic         sdMiso;
   logic         sdMosi;
   logic         sdSclk;
   logic         sdCs;

   // Card model control and observation
   logic [7:0]   respDelay;
   logic [7:0]   r1Value;
   logic         injectCrcError;
   logic [5:0]   capIndex;
   logic [31:0]  capArg;
   logic [7:0]   capCrcByte;
   logic         crcOk;
   logic [15:0]  initClocks;
   logic [15:0]  frameCount;

   cmdRow_t      rows[$];
   logic [31:0]  lfsrState = 32'hf574_ae01;
   int           errCount = 0;
   int           checkCount = 0;
   int           csErrors = 0;
   int           curRow = -1;
   int           curDiv;

   // Raised when a wait runs out
   logic         stopReq = 1'b0;
   string        stopReason;

   // SCLK period monitor
   int           cycleCnt = 0;
   int           firstRise = 0;
   int           riseCount = 0;
   int           sclkPeriod = 0;
   logic         sclkLast = 1'b1;

   always #4 clk = ~clk;

   sdSpiTop sdSpiTop_inst
   (
      .clk         (clk),
      .rst         (rst),
      .initStart   (initStart),
      .cmdStart    (cmdStart),
      .cmdIndex    (cmdIndex),
      .cmdArg      (cmdArg),
      .setFast     (setFast),
      .setSlow     (setSlow),
      .busy        (busy),
      .cmdDone     (cmdDone),
      .resp        (resp),
      .respTimeout (respTimeout),
      .sdMiso      (sdMiso),
      .sdMosi      (sdMosi),
      .sdSclk      (sdSclk),
      .sdCs        (sdCs)
   );

   sdCardModel cardModel
   (
      .rst            (rst),
      .sclk           (sdSclk),
      .cs             (sdCs),
      .mosi           (sdMosi),
      .miso           (sdMiso),
      .respDelay      (respDelay),
      .r1Value        (r1Value),
      .injectCrcError (injectCrcError),
      .capIndex       (capIndex),
      .capArg         (capArg),
      .capCrcByte     (capCrcByte),
      .crcOk          (crcOk),
      .initClocks     (initClocks),
      .frameCount     (frameCount)
   );

   //////////////////////////////////////////////////////////////////////
   // Monitors
   //////////////////////////////////////////////////////////////////////

   // Spacing of the first two rising edges of each command
   always @(posedge clk)
   begin
      cycleCnt <= cycleCnt + 1;
      sclkLast <= sdSclk;
      if (cmdStart)
         riseCount <= 0;
      else if (sdSclk && !sclkLast)
      begin
         if (riseCount == 0)
            firstRise <= cycleCnt;
         else if (riseCount == 1)
            sclkPeriod <= cycleCnt - firstRise;
         riseCount <= riseCount + 1;
      end
   end

   // Card deselected whenever idle
   always @(posedge clk)
   begin
      if (!rst && busy === 1'b0 && sdCs !== 1'b1)
      begin
         csErrors <= csErrors + 1;
         $display("** Error: sdCs = 0x%0h while busy low, expected 0x1", sdCs);
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] lfsrNext(input logic [31:0] s);
      // Taps 32, 22, 2, 1
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One step per bit taken
   task automatic randomWord(output logic [31:0] w);
      w = 32'd0;
      for (int i = 0; i < 32; i++)
      begin
         lfsrState = lfsrNext(lfsrState);
         w = {w[30:0], lfsrState[0]};
      end
   endtask

   task automatic expectValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checkCount++;
      if (got !== exp)
      begin
         errCount++;
         $display("** Error: row %0d %s = 0x%0h, expected 0x%0h", curRow, name, got, exp);
      end
   endtask

   // Hands the run over to the stop process and parks the caller
   task automatic abortRun(input string reason);
      errCount++;
      stopReason = reason;
      stopReq    = 1'b1;
      forever
         @(posedge clk);
   endtask

   task automatic waitDone(input string what);
      int n;
      n = 0;
      while (cmdDone !== 1'b1 && n < DoneLimit)
      begin
         @(posedge clk);
         n++;
      end
      if (cmdDone !== 1'b1)
         abortRun($sformatf("no cmdDone for %s in row %0d", what, curRow));
   endtask

   task automatic addRow(input logic [1:0] speed, input logic randArg, input logic [5:0] index,
                         input logic [31:0] arg, input logic badCrc, input logic [7:0] delay,
                         input logic [7:0] r1, input logic [7:0] expResp,
                         input logic expTimeout, input logic [7:0] expCrcByte);
      cmdRow_t r;
      r.speed      = speed;
      r.randArg    = randArg;
      r.index      = index;
      r.arg        = arg;
      r.badCrc     = badCrc;
      r.delay      = delay;
      r.r1         = r1;
      r.expResp    = expResp;
      r.expTimeout = expTimeout;
      r.expCrcByte = expCrcByte;
      rows.push_back(r);
   endtask

   task automatic buildTable();
      // Slow speed, CMD0 and CMD8 have well known CRC bytes
      addRow(2, 0, 0, 32'h0000_0000, 0, 1, 8'h01, 8'h01, 0, 8'h95);
      addRow(0, 0, 8, 32'h0000_01aa, 0, 2, 8'h01, 8'h01, 0, 8'h87);
      addRow(0, 0, 17, 32'h0000_1234, 0, 1, 8'h00, 8'h00, 0, 8'h00);
      // Poll window edges
      addRow(0, 0, 55, 32'h0000_0000, 0, 8'(`SD_POLL_MAX - 1), 8'h01, 8'h01, 0, 8'h00);
      addRow(0, 0, 41, 32'h4000_0000, 0, 8'(`SD_POLL_MAX + 2), 8'h00, 8'hff, 1, 8'h00);
      // Line error seen by the card
      addRow(0, 0, 24, 32'h0000_0200, 1, 1, 8'h00, 8'h09, 0, 8'h00);
      // Fast speed
      addRow(1, 0, 0, 32'h0000_0000, 0, 1, 8'h01, 8'h01, 0, 8'h95);
      addRow(0, 0, 8, 32'h0000_01aa, 0, 3, 8'h01, 8'h01, 0, 8'h87);
      addRow(0, 1, 17, 32'h0000_0000, 0, 4, 8'h00, 8'h00, 0, 8'h00);
      addRow(0, 1, 24, 32'h0000_0000, 0, 5, 8'h04, 8'h04, 0, 8'h00);
      addRow(0, 1, 12, 32'h0000_0000, 0, 1, 8'h00, 8'h00, 0, 8'h00);
      addRow(0, 0, 58, 32'h0000_0000, 0, 8'(`SD_POLL_MAX + 1), 8'h00, 8'hff, 1, 8'h00);
      // Back to slow
      addRow(2, 1, 18, 32'h0000_0000, 0, 2, 8'h00, 8'h00, 0, 8'h00);
      addRow(0, 0, 16, 32'h0000_0200, 0, 1, 8'h00, 8'h00, 0, 8'h00);
   endtask

   //////////////////////////////////////////////////////////////////////
   // One table row
   //////////////////////////////////////////////////////////////////////

   task automatic runRow(input cmdRow_t r);
      logic [31:0]  arg;
      logic [15:0]  prevFrames;
      if (r.speed == 2'd1)
      begin
         setFast <= 1'b1;
         @(posedge clk);
         setFast <= 1'b0;
         @(posedge clk);
         curDiv = `SD_FAST_DIV;
      end
      else if (r.speed == 2'd2)
      begin
         setSlow <= 1'b1;
         @(posedge clk);
         setSlow <= 1'b0;
         @(posedge clk);
         curDiv = `SD_SLOW_DIV;
      end
      if (r.randArg)
         randomWord(arg);
      else
         arg = r.arg;
      prevFrames = frameCount;
      respDelay      <= r.delay;
      r1Value        <= r.r1;
      injectCrcError <= r.badCrc;
      cmdIndex       <= r.index;
      cmdArg         <= arg;
      cmdStart       <= 1'b1;
      @(posedge clk);
      cmdStart <= 1'b0;
      waitDone("command");
      // Results at the done cycle
      expectValue("resp", resp, r.expResp);
      expectValue("respTimeout", respTimeout, r.expTimeout);
      expectValue("busy", busy, 1'b0);
      expectValue("sdCs", sdCs, 1'b1);
      // What the card saw
      expectValue("frameCount", frameCount, prevFrames + 16'd1);
      expectValue("capIndex", capIndex, r.index);
      expectValue("capArg", capArg, arg);
      expectValue("crcOk", crcOk, !r.badCrc);
      if (r.expCrcByte != 8'h00)
         expectValue("capCrcByte", capCrcByte, r.expCrcByte);
      expectValue("sclkPeriod", sclkPeriod, 2 * (curDiv + 1));
   endtask

   // Second start while busy must be dropped
   task automatic checkBusyIgnore();
      logic [15:0]  prevFrames;
      int           n;
      int           extraDone;
      int           extraBusy;
      prevFrames     = frameCount;
      respDelay      <= 8'd1;
      r1Value        <= 8'h00;
      injectCrcError <= 1'b0;
      cmdIndex       <= 6'd13;
      cmdArg         <= 32'h0000_0000;
      cmdStart       <= 1'b1;
      @(posedge clk);
      cmdStart <= 1'b0;
      n = 0;
      while (busy !== 1'b1 && n < BusyLimit)
      begin
         @(posedge clk);
         n++;
      end
      if (busy !== 1'b1)
         abortRun("busy never rose after cmdStart");
      cmdIndex <= 6'd17;
      cmdStart <= 1'b1;
      @(posedge clk);
      cmdStart <= 1'b0;
      waitDone("busy test");
      expectValue("resp", resp, 8'h00);
      expectValue("capIndex", capIndex, 6'd13);
      // Quiet window after the single done
      extraDone = 0;
      extraBusy = 0;
      repeat (400)
      begin
         @(posedge clk);
         if (cmdDone)
            extraDone++;
         if (busy)
            extraBusy++;
      end
      expectValue("cmdDone extra pulses", extraDone, 0);
      expectValue("busy cycles after done", extraBusy, 0);
      expectValue("frameCount", frameCount, prevFrames + 16'd1);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////////////////////////

   // Closes a run that stalled
   initial
   begin
      wait (stopReq);
      $display("Run stopped: %s", stopReason);
      $display("Checks: %0d, errors: %0d", checkCount, errCount + csErrors);
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial
   begin
      rst            = 1'b1;
      initStart      = 1'b0;
      cmdStart       = 1'b0;
      cmdIndex       = 6'd0;
      cmdArg         = 32'd0;
      setFast        = 1'b0;
      setSlow        = 1'b0;
      respDelay      = 8'd1;
      r1Value        = 8'h00;
      injectCrcError = 1'b0;
      curDiv         = `SD_SLOW_DIV;
      buildTable();
      repeat (16) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      // Reset state
      expectValue("sdCs", sdCs, 1'b1);
      expectValue("sdSclk", sdSclk, 1'b1);
      expectValue("sdMosi", sdMosi, 1'b1);
      expectValue("busy", busy, 1'b0);
      expectValue("cmdDone", cmdDone, 1'b0);
      expectValue("resp", resp, 8'hff);
      expectValue("respTimeout", respTimeout, 1'b0);
      // Power-up clock train
      initStart <= 1'b1;
      @(posedge clk);
      initStart <= 1'b0;
      waitDone("init");
      expectValue("initClocks", initClocks, 8 * `SD_INIT_BYTES);
      expectValue("sdCs", sdCs, 1'b1);
      expectValue("busy", busy, 1'b0);
      foreach (rows[i])
      begin
         curRow = i;
         runRow(rows[i]);
      end
      curRow = rows.size();
      checkBusyIgnore();
      $display("Checks: %0d, errors: %0d", checkCount, errCount + csErrors);
      if (errCount + csErrors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

// File: sim.f
+incdir+include
design/sdSpiPkg.sv
design/sdSpiPhy.sv
design/sdCmdSequencer.sv
design/sdSpiTop.sv
tests/sdCardModel.sv
tests/sdSpiTb.sv
